/* Makefile */
# Verilator flow for the scoreboard testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module sched_tb -f sim.f

# Pass only when the testbench prints its pass line
run: compile
	@out="$$(./obj_dir/Vsched_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

/* common/sched_pkg.sv */
/*
 * Shared widths and types of the scoreboard. NUM_TAGS sets the tag count and
 * the depth of the table and wait buffer; it must stay a power of two.
 */
package sched_pkg;

    // ##################
    // Sizes
    // ##################

    // In-flight instruction count, one tag each
    parameter int unsigned NUM_TAGS = 8;

    // Tag width follows the tag count
    parameter int unsigned TAG_W = $clog2(NUM_TAGS);

    // Architectural register index
    parameter int unsigned REG_IDX_W = 6;

    // Subwarp id, four subwarps
    parameter int unsigned SUBWARP_W = 2;

    // Source operands per instruction
    parameter int unsigned NUM_OPS = 2;

    // ##################
    // Types
    // ##################

    // Instruction tag
    typedef logic [TAG_W-1:0] tag_t;

    // Register index
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // Subwarp id
    typedef logic [SUBWARP_W-1:0] subwarp_t;

endpackage

/* reg_table/reg_table.sv */
/*
 * Pending-writer table, one entry per tag. No space check on insert;
 * a free tag upstream implies a free entry. Source outputs are combinational.
 */
module reg_table (
    input  logic                                          clk_i,
    input  logic                                          arst_n_i,
    input  logic                                          insert_i,
    input  sched_pkg::tag_t                               tag_i,
    input  sched_pkg::subwarp_t                           subwarp_i,
    input  sched_pkg::reg_idx_t                           dst_i,
    input  sched_pkg::reg_idx_t [sched_pkg::NUM_OPS-1:0]  src_i,
    input  logic                                          cpl_valid_i,
    input  sched_pkg::tag_t                               cpl_tag_i,
    output logic                [sched_pkg::NUM_OPS-1:0]  src_ready_o,
    output sched_pkg::tag_t     [sched_pkg::NUM_OPS-1:0]  src_tag_o,
    output logic                                          all_dst_written_o
);

    // ##################
    // Entry state
    // ##################

    logic                [sched_pkg::NUM_TAGS-1:0] table_valid_q, table_valid_d;
    sched_pkg::subwarp_t [sched_pkg::NUM_TAGS-1:0] table_subwarp_q, table_subwarp_d;
    sched_pkg::reg_idx_t [sched_pkg::NUM_TAGS-1:0] table_dst_q, table_dst_d;
    sched_pkg::tag_t     [sched_pkg::NUM_TAGS-1:0] table_producer_q, table_producer_d;

    // Destination lookup results
    logic            dst_hit;
    sched_pkg::tag_t dst_hit_idx;
    sched_pkg::tag_t free_idx;

    // Nothing pending once every entry is clear
    assign all_dst_written_o = ~|table_valid_q;

    // ##################
    // Source lookup
    // ##################

    always_comb begin
        for (int op = 0; op < sched_pkg::NUM_OPS; op++) begin
            src_ready_o[op] = 1'b1;
            src_tag_o[op]   = '0;
            // Downward scan so the lowest matching entry wins
            for (int e = sched_pkg::NUM_TAGS - 1; e >= 0; e--) begin
                if (table_valid_q[e] && table_subwarp_q[e] == subwarp_i
                    && table_dst_q[e] == src_i[op]) begin
                    src_ready_o[op] = 1'b0;
                    src_tag_o[op]   = table_producer_q[e];
                end
            end
            // Producer finishing this cycle
            if (!src_ready_o[op] && cpl_valid_i && cpl_tag_i == src_tag_o[op]) begin
                src_ready_o[op] = 1'b1;
            end
        end
    end

    // ##################
    // Destination lookup
    // ##################

    always_comb begin
        dst_hit     = 1'b0;
        dst_hit_idx = '0;
        free_idx    = '0;
        for (int e = sched_pkg::NUM_TAGS - 1; e >= 0; e--) begin
            // Existing entry for the same register of this subwarp
            if (table_valid_q[e] && table_subwarp_q[e] == subwarp_i
                && table_dst_q[e] == dst_i) begin
                dst_hit     = 1'b1;
                dst_hit_idx = sched_pkg::tag_t'(e);
            end
            // Lowest empty entry
            if (!table_valid_q[e]) begin
                free_idx = sched_pkg::tag_t'(e);
            end
        end
    end

    // ##################
    // Next state
    // ##################

    always_comb begin
        table_valid_d    = table_valid_q;
        table_subwarp_d  = table_subwarp_q;
        table_dst_d      = table_dst_q;
        table_producer_d = table_producer_q;

        // Completion retires every entry of that producer
        if (cpl_valid_i) begin
            for (int e = 0; e < sched_pkg::NUM_TAGS; e++) begin
                if (table_valid_q[e] && table_producer_q[e] == cpl_tag_i) begin
                    table_valid_d[e] = 1'b0;
                end
            end
        end

        if (insert_i) begin
            if (dst_hit) begin
                // Newer writer takes over, valid again even if cleared above
                table_valid_d[dst_hit_idx]    = 1'b1;
                table_producer_d[dst_hit_idx] = tag_i;
            end else begin
                table_valid_d[free_idx]    = 1'b1;
                table_subwarp_d[free_idx]  = subwarp_i;
                table_dst_d[free_idx]      = dst_i;
                table_producer_d[free_idx] = tag_i;
            end
        end
    end

    // ##################
    // Registers
    // ##################

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            table_valid_q <= '0;
        end else begin
            table_valid_q <= table_valid_d;
        end
    end

    // Entry fields, qualified by the valid bits
    always_ff @(posedge clk_i) begin
        table_subwarp_q  <= table_subwarp_d;
        table_dst_q      <= table_dst_d;
        table_producer_q <= table_producer_d;
    end

endmodule

/* sim.f */
common/sched_pkg.sv
reg_table/reg_table.sv
verilog/tag_pool.sv
verilog/wait_buffer.sv
verilog/exec_pipe.sv
verilog/sched_top.sv
sim/sched_props.sv
sim/sched_tb.sv

/* sim/sched_props.sv */
/*
 * Scoreboard invariants, bound into sched_top. Table fields come from the
 * reg_table instance and count only while their valid bit is set.
 */
module sched_props (
    input logic                                          clk_i,
    input logic                                          arst_n_i,
    input logic                                          insert_i,
    input logic                                          inst_ready_i,
    input logic                                          in_flight_i,
    input logic                [sched_pkg::NUM_TAGS-1:0] valid_i,
    input sched_pkg::subwarp_t [sched_pkg::NUM_TAGS-1:0] subwarp_i,
    input sched_pkg::reg_idx_t [sched_pkg::NUM_TAGS-1:0] dst_i,
    input sched_pkg::tag_t     [sched_pkg::NUM_TAGS-1:0] producer_i
);

    logic dup_key;
    logic dup_producer;

    // Pairwise scan of valid entries
    always_comb begin
        dup_key      = 1'b0;
        dup_producer = 1'b0;
        for (int a = 0; a < sched_pkg::NUM_TAGS; a++) begin
            for (int b = a + 1; b < sched_pkg::NUM_TAGS; b++) begin
                if (valid_i[a] && valid_i[b]) begin
                    if (subwarp_i[a] == subwarp_i[b] && dst_i[a] == dst_i[b]) begin
                        dup_key = 1'b1;
                    end
                    if (producer_i[a] == producer_i[b]) begin
                        dup_producer = 1'b1;
                    end
                end
            end
        end
    end

    // A free tag upstream implies a free entry
    free_entry: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        insert_i |-> !(&valid_i))
        else $error("Insert while every table entry is valid");

    unique_key: assert property (@(posedge clk_i) disable iff (!arst_n_i) !dup_key)
        else $error("Two valid entries for one subwarp register");

    unique_producer: assert property (@(posedge clk_i) disable iff (!arst_n_i) !dup_producer)
        else $error("Two valid entries with one producer tag");

    // Nothing waiting, dispatching or executing means every tag is back in the pool
    idle_ready: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !in_flight_i |-> inst_ready_i)
        else $error("Ready low with no instruction in flight");

endmodule

bind sched_top sched_props u_sched_props (
    .clk_i, .arst_n_i, .insert_i(accept), .inst_ready_i(inst_ready_o),
    .in_flight_i(|u_wait_buffer.slot_valid_q || u_wait_buffer.disp_valid_q
                 || |u_exec_pipe.stage_valid_q),
    .valid_i(u_reg_table.table_valid_q),
    .subwarp_i(u_reg_table.table_subwarp_q), .dst_i(u_reg_table.table_dst_q),
    .producer_i(u_reg_table.table_producer_q)
);

/* sim/sched_tb.sv */
/*
 * Testbench for sched_top. Rows are held until accepted; a reference model
 * of pending writers per subwarp register checks every writeback.
 */
module sched_tb;

    localparam int EXEC_LATENCY = 3;
    localparam int MAX_ROWS     = 80;
    localparam int NUM_TESTS    = 6;

    logic                clk_i = 1'b0;
    logic                arst_n_i;
    logic                inst_valid_i;
    sched_pkg::subwarp_t inst_subwarp_i;
    sched_pkg::reg_idx_t inst_dst_i;
    sched_pkg::reg_idx_t inst_src0_i;
    sched_pkg::reg_idx_t inst_src1_i;
    logic                inst_ready_o;
    sched_pkg::tag_t     inst_tag_o;
    logic                wb_valid_o;
    sched_pkg::tag_t     wb_tag_o;
    sched_pkg::subwarp_t wb_subwarp_o;
    sched_pkg::reg_idx_t wb_dst_o;
    logic                all_dst_written_o;

    // ##################
    // Stimulus table and model
    // ##################

    sched_pkg::subwarp_t row_sw[MAX_ROWS];
    sched_pkg::reg_idx_t row_dst[MAX_ROWS];
    sched_pkg::reg_idx_t row_src[MAX_ROWS][2];
    int                  row_gap[MAX_ROWS];
    // Producer row per source or -1 when ready on insert
    int                  row_prod[MAX_ROWS][2];
    // Cycle of acceptance or -1 until accepted
    int                  row_acc_cyc[MAX_ROWS];
    // Position in retire order or -1 until retired
    int                  row_ret_seq[MAX_ROWS];
    // Latest accepted writer per subwarp register
    int                  last_writer[256];
    // Row holding each tag or -1 when free
    int                  tag_row[sched_pkg::NUM_TAGS];
    string               test_name[NUM_TESTS];
    int                  test_last[NUM_TESTS];

    int          n_rows = 0;
    int          n_accepted = 0;
    int          n_retired = 0;
    int          cycle = 0;
    int          limit = 100;
    int          checks_ok = 0;
    int          checks_bad = 0;
    logic [31:0] lfsr_q = 32'h897d;

    always #4 clk_i = ~clk_i;

    sched_top #(.EXEC_LATENCY(EXEC_LATENCY)) u_sched_top (.*);

    // Ends a run that stops making progress
    initial begin
        wait (cycle > limit);
        $display("Timeout after %0d cycles with %0d rows in flight",
                 cycle, n_accepted - n_retired);
        $display("Checks failed");
        $finish;
    end

    function automatic int reg_key(input sched_pkg::subwarp_t sw, input sched_pkg::reg_idx_t r);
        return int'({sw, r});
    endfunction

    // Galois LFSR with x^32 + x^22 + x^2 + x + 1
    function automatic logic next_rand_bit();
        logic lsb;
        lsb    = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (lsb) begin
            lfsr_q = lfsr_q ^ 32'h8020_0003;
        end
        return lsb;
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(next_rand_bit());
        end
        return v;
    endfunction

    // Table entry stays valid while its latest writer is in flight
    function automatic logic writer_pending();
        logic busy;
        busy = 1'b0;
        for (int r = 0; r < n_rows; r++) begin
            if (row_acc_cyc[r] >= 0 && row_ret_seq[r] < 0
                && last_writer[reg_key(row_sw[r], row_dst[r])] == r) begin
                busy = 1'b1;
            end
        end
        return busy;
    endfunction

    // ##################
    // Checks
    // ##################

    task automatic record_check(input logic ok, input string name, input int got, input int exp);
        if (ok) begin
            checks_ok++;
        end else begin
            checks_bad++;
            $display("Fail at %0t: %s got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_tag(input string name, input sched_pkg::tag_t got,
                             input sched_pkg::tag_t exp);
        record_check(got === exp, name, int'(got), int'(exp));
    endtask

    task automatic check_reg(input string name, input sched_pkg::reg_idx_t got,
                             input sched_pkg::reg_idx_t exp);
        record_check(got === exp, name, int'(got), int'(exp));
    endtask

    task automatic check_subwarp(input string name, input sched_pkg::subwarp_t got,
                                 input sched_pkg::subwarp_t exp);
        record_check(got === exp, name, int'(got), int'(exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        record_check(got === exp, name, int'(got), int'(exp));
    endtask

    task automatic report_error(input string msg);
        checks_bad++;
        $display("%s", msg);
    endtask

    // ##################
    // Row handling
    // ##################

    task automatic add_row(input int sw, input int dst, input int s0, input int s1, input int gap);
        row_sw[n_rows]      = sched_pkg::subwarp_t'(sw);
        row_dst[n_rows]     = sched_pkg::reg_idx_t'(dst);
        row_src[n_rows][0]  = sched_pkg::reg_idx_t'(s0);
        row_src[n_rows][1]  = sched_pkg::reg_idx_t'(s1);
        row_gap[n_rows]     = gap;
        row_acc_cyc[n_rows] = -1;
        row_ret_seq[n_rows] = -1;
        n_rows++;
    endtask

    // Subwarps 0 and 1 with registers 0 to 7
    task automatic add_random_row();
        int sw;
        int dst;
        int s0;
        int s1;
        int gap;
        sw  = rand_bits(1);
        dst = rand_bits(3);
        s0  = rand_bits(3);
        s1  = rand_bits(3);
        gap = rand_bits(1);
        add_row(sw, dst, s0, s1, gap);
    endtask

    // Producers resolved before the row becomes the latest writer
    task automatic accept_row(input int r);
        int w;
        if (tag_row[inst_tag_o] >= 0) begin
            report_error($sformatf("Tag %0d handed out while still in flight", inst_tag_o));
        end
        if (r == 0) begin
            check_tag("inst_tag_o", inst_tag_o, '0);
        end
        for (int op = 0; op < 2; op++) begin
            w = last_writer[reg_key(row_sw[r], row_src[r][op])];
            row_prod[r][op] = (w >= 0 && row_ret_seq[w] < 0) ? w : -1;
        end
        last_writer[reg_key(row_sw[r], row_dst[r])] = r;
        tag_row[inst_tag_o] = r;
        row_acc_cyc[r]      = cycle;
        n_accepted++;
    endtask

    task automatic retire_tag(input sched_pkg::tag_t tag);
        int r;
        r = tag_row[tag];
        if (r < 0) begin
            report_error($sformatf("Writeback of tag %0d that is not in flight", tag));
        end else begin
            check_subwarp("wb_subwarp_o", wb_subwarp_o, row_sw[r]);
            check_reg("wb_dst_o", wb_dst_o, row_dst[r]);
            for (int op = 0; op < 2; op++) begin
                if (row_prod[r][op] >= 0 && row_ret_seq[row_prod[r][op]] < 0) begin
                    report_error($sformatf("Row %0d retired before its producer row %0d",
                                           r, row_prod[r][op]));
                end
            end
            // Seen one falling edge after the writeback edge
            if (r == 0) begin
                check_tag("wb_tag_o", tag, '0);
                record_check(cycle - row_acc_cyc[r] - 1 == EXEC_LATENCY + 1,
                             "wb_valid_o latency", cycle - row_acc_cyc[r] - 1, EXEC_LATENCY + 1);
            end
            row_ret_seq[r] = n_retired;
            tag_row[tag]   = -1;
            n_retired++;
        end
    endtask

    // One falling edge that checks state, takes the writeback and drives inputs
    task automatic step_cycle(input logic vld, input int r);
        @(negedge clk_i);
        cycle++;
        check_bit("inst_ready_o", inst_ready_o,
                  (n_accepted - n_retired) < int'(sched_pkg::NUM_TAGS));
        check_bit("all_dst_written_o", all_dst_written_o, !writer_pending());
        // Completion first so that it counts for a source inserted in the same cycle
        if (wb_valid_o) begin
            retire_tag(wb_tag_o);
        end
        inst_valid_i = vld;
        if (vld) begin
            inst_subwarp_i = row_sw[r];
            inst_dst_i     = row_dst[r];
            inst_src0_i    = row_src[r][0];
            inst_src1_i    = row_src[r][1];
        end
        if (vld && inst_ready_o) begin
            accept_row(r);
        end
    endtask

    task automatic apply_row(input int r);
        repeat (row_gap[r]) step_cycle(1'b0, r);
        step_cycle(1'b1, r);
        while (row_acc_cyc[r] < 0) begin
            step_cycle(1'b1, r);
        end
    endtask

    task automatic drain_pipe();
        while (n_accepted != n_retired) begin
            step_cycle(1'b0, 0);
        end
        step_cycle(1'b0, 0);
        check_bit("all_dst_written_o", all_dst_written_o, 1'b1);
    endtask

    // ##################
    // Test sequence
    // ##################

    initial begin
        int first;
        int bad_before;
        arst_n_i       = 1'b0;
        inst_valid_i   = 1'b0;
        inst_subwarp_i = '0;
        inst_dst_i     = '0;
        inst_src0_i    = '0;
        inst_src1_i    = '0;
        for (int k = 0; k < 256; k++) begin
            last_writer[k] = -1;
        end
        for (int t = 0; t < int'(sched_pkg::NUM_TAGS); t++) begin
            tag_row[t] = -1;
        end

        // Rows give subwarp, destination, source 0, source 1 and idle gap
        test_name[0] = "latency";
        add_row(0, 5, 6, 7, 0);
        test_last[0] = n_rows - 1;
        test_name[1] = "raw chain";
        add_row(0, 1, 0, 0, 2);
        add_row(0, 2, 1, 1, 0);
        add_row(0, 3, 2, 0, 0);
        add_row(0, 4, 3, 3, 1);
        test_last[1] = n_rows - 1;
        // A0 and A1 in subwarp 0 followed by B in subwarp 1
        test_name[2] = "subwarp isolation";
        add_row(0, 1, 12, 13, 1);
        add_row(0, 2, 1, 1, 0);
        add_row(1, 20, 2, 2, 0);
        test_last[2] = n_rows - 1;
        // Slow rewrite of r30 over a fast pending writer and a reader after it
        test_name[3] = "waw and back-pressure";
        add_row(2, 40, 41, 41, 1);
        add_row(2, 42, 40, 40, 0);
        add_row(2, 30, 43, 43, 0);
        add_row(2, 30, 42, 42, 0);
        add_row(2, 31, 30, 30, 0);
        for (int k = 0; k < 10; k++) begin
            add_row(3, k + 1, k, k, 0);
        end
        test_last[3] = n_rows - 1;
        test_name[4] = "drain";
        add_row(1, 50, 51, 52, 3);
        add_row(1, 51, 50, 50, 0);
        test_last[4] = n_rows - 1;
        test_name[5] = "random stream";
        repeat (40) add_random_row();
        test_last[5] = n_rows - 1;

        for (int r = 0; r < n_rows; r++) begin
            limit += row_gap[r] + EXEC_LATENCY + int'(sched_pkg::NUM_TAGS) + 2;
        end

        repeat (10) @(negedge clk_i);
        arst_n_i = 1'b1;

        first = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            bad_before = checks_bad;
            for (int r = first; r <= test_last[t]; r++) begin
                apply_row(r);
            end
            drain_pipe();
            // B has no producers and must overtake A1
            if (t == 2 && row_ret_seq[test_last[2]] > row_ret_seq[test_last[2] - 1]) begin
                report_error("Subwarp 1 row retired after the subwarp 0 row it should overtake");
            end
            $display("Test %0d %s: %0d wrong", t + 1, test_name[t], checks_bad - bad_before);
            first = test_last[t] + 1;
        end

        if (n_accepted != n_rows || n_retired != n_accepted) begin
            report_error($sformatf("Only %0d of %0d rows accepted, %0d retired",
                                   n_accepted, n_rows, n_retired));
        end
        $display("Counts: %0d checks passed, %0d wrong, %0d rows accepted, %0d retired",
                 checks_ok, checks_bad, n_accepted, n_retired);
        if (checks_bad == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* verilog/exec_pipe.sv */
/*
 * Fixed-latency stand-in for the execution unit with EXEC_LATENCY of 1 or more.
 * It never stalls and outputs appear exactly EXEC_LATENCY edges after input.
 */
module exec_pipe #(
    parameter int unsigned EXEC_LATENCY = 3
) (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                in_valid_i,
    input  sched_pkg::tag_t     in_tag_i,
    input  sched_pkg::subwarp_t in_subwarp_i,
    input  sched_pkg::reg_idx_t in_dst_i,
    output logic                out_valid_o,
    output sched_pkg::tag_t     out_tag_o,
    output sched_pkg::subwarp_t out_subwarp_o,
    output sched_pkg::reg_idx_t out_dst_o
);

    // Stage 0 takes the input and the last stage drives the output
    logic                [EXEC_LATENCY-1:0] stage_valid_q;
    sched_pkg::tag_t     [EXEC_LATENCY-1:0] stage_tag_q;
    sched_pkg::subwarp_t [EXEC_LATENCY-1:0] stage_subwarp_q;
    sched_pkg::reg_idx_t [EXEC_LATENCY-1:0] stage_dst_q;

    // Valid bits clear on reset
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            stage_valid_q <= '0;
        end else begin
            stage_valid_q[0] <= in_valid_i;
            for (int s = 1; s < int'(EXEC_LATENCY); s++) begin
                stage_valid_q[s] <= stage_valid_q[s-1];
            end
        end
    end

    // Payload shifts with its valid bit
    always_ff @(posedge clk_i) begin
        stage_tag_q[0]     <= in_tag_i;
        stage_subwarp_q[0] <= in_subwarp_i;
        stage_dst_q[0]     <= in_dst_i;
        for (int s = 1; s < int'(EXEC_LATENCY); s++) begin
            stage_tag_q[s]     <= stage_tag_q[s-1];
            stage_subwarp_q[s] <= stage_subwarp_q[s-1];
            stage_dst_q[s]     <= stage_dst_q[s-1];
        end
    end

    assign out_valid_o   = stage_valid_q[EXEC_LATENCY-1];
    assign out_tag_o     = stage_tag_q[EXEC_LATENCY-1];
    assign out_subwarp_o = stage_subwarp_q[EXEC_LATENCY-1];
    assign out_dst_o     = stage_dst_q[EXEC_LATENCY-1];

endmodule

/* verilog/sched_top.sv */
/*
 * Scoreboard top. inst_tag_o is valid only while inst_ready_o is high;
 * the source must hold its instruction until accepted.
 */
module sched_top #(
    parameter int unsigned EXEC_LATENCY = 3
) (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                inst_valid_i,
    input  sched_pkg::subwarp_t inst_subwarp_i,
    input  sched_pkg::reg_idx_t inst_dst_i,
    input  sched_pkg::reg_idx_t inst_src0_i,
    input  sched_pkg::reg_idx_t inst_src1_i,
    output logic                inst_ready_o,
    output sched_pkg::tag_t     inst_tag_o,
    output logic                wb_valid_o,
    output sched_pkg::tag_t     wb_tag_o,
    output sched_pkg::subwarp_t wb_subwarp_o,
    output sched_pkg::reg_idx_t wb_dst_o,
    output logic                all_dst_written_o
);

    logic                                         accept;
    sched_pkg::reg_idx_t [sched_pkg::NUM_OPS-1:0] src_regs;
    logic                [sched_pkg::NUM_OPS-1:0] src_ready;
    sched_pkg::tag_t     [sched_pkg::NUM_OPS-1:0] src_tag;
    logic                                         disp_valid;
    sched_pkg::tag_t                              disp_tag;
    sched_pkg::subwarp_t                          disp_subwarp;
    sched_pkg::reg_idx_t                          disp_dst;
    logic                                         cpl_valid;
    sched_pkg::tag_t                              cpl_tag;

    // Handshake, ready means a tag is free
    assign accept   = inst_valid_i & inst_ready_o;
    assign src_regs = {inst_src1_i, inst_src0_i};

    tag_pool u_tag_pool (
        .clk_i, .arst_n_i, .alloc_i(accept), .free_valid_i(cpl_valid),
        .free_tag_i(cpl_tag), .has_free_o(inst_ready_o), .free_tag_o(inst_tag_o)
    );

    reg_table u_reg_table (
        .clk_i, .arst_n_i, .insert_i(accept), .tag_i(inst_tag_o),
        .subwarp_i(inst_subwarp_i), .dst_i(inst_dst_i), .src_i(src_regs),
        .cpl_valid_i(cpl_valid), .cpl_tag_i(cpl_tag), .src_ready_o(src_ready),
        .src_tag_o(src_tag), .all_dst_written_o
    );

    // Slot index equals the tag just handed out
    wait_buffer u_wait_buffer (
        .clk_i, .arst_n_i, .insert_i(accept), .tag_i(inst_tag_o),
        .subwarp_i(inst_subwarp_i), .dst_i(inst_dst_i), .src_ready_i(src_ready),
        .src_tag_i(src_tag), .cpl_valid_i(cpl_valid), .cpl_tag_i(cpl_tag),
        .disp_valid_o(disp_valid), .disp_tag_o(disp_tag),
        .disp_subwarp_o(disp_subwarp), .disp_dst_o(disp_dst)
    );

    // Completion broadcast doubles as writeback
    exec_pipe #(.EXEC_LATENCY(EXEC_LATENCY)) u_exec_pipe (
        .clk_i, .arst_n_i, .in_valid_i(disp_valid), .in_tag_i(disp_tag),
        .in_subwarp_i(disp_subwarp), .in_dst_i(disp_dst), .out_valid_o(cpl_valid),
        .out_tag_o(cpl_tag), .out_subwarp_o(wb_subwarp_o), .out_dst_o(wb_dst_o)
    );

    assign wb_valid_o = cpl_valid;
    assign wb_tag_o   = cpl_tag;

endmodule

/* verilog/tag_pool.sv */
/*
 * Busy bitmap of tags. Caller allocates only while has_free_o is high.
 * A tag freed here must be one that is currently allocated.
 */
module tag_pool (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  logic            alloc_i,
    input  logic            free_valid_i,
    input  sched_pkg::tag_t free_tag_i,
    output logic            has_free_o,
    output sched_pkg::tag_t free_tag_o
);

    // One bit per tag, set while in flight
    logic [sched_pkg::NUM_TAGS-1:0] busy_q, busy_d;

    // Any clear bit means a tag is on offer
    assign has_free_o = ~&busy_q;

    // Lowest clear bit
    always_comb begin
        free_tag_o = '0;
        for (int t = sched_pkg::NUM_TAGS - 1; t >= 0; t--) begin
            if (!busy_q[t]) begin
                free_tag_o = sched_pkg::tag_t'(t);
            end
        end
    end

    // Free and allocate never hit the same tag in one cycle
    always_comb begin
        busy_d = busy_q;
        if (free_valid_i) begin
            busy_d[free_tag_i] = 1'b0;
        end
        if (alloc_i) begin
            busy_d[free_tag_o] = 1'b1;
        end
    end

    // All tags free after reset
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q <= '0;
        end else begin
            busy_q <= busy_d;
        end
    end

endmodule

/* verilog/wait_buffer.sv */
/*
 * Wait buffer with one slot per tag, written at the slot of the new tag.
 * Dispatch output is registered; at most one entry leaves per cycle.
 */
module wait_buffer (
    input  logic                                      clk_i,
    input  logic                                      arst_n_i,
    input  logic                                      insert_i,
    input  sched_pkg::tag_t                           tag_i,
    input  sched_pkg::subwarp_t                       subwarp_i,
    input  sched_pkg::reg_idx_t                       dst_i,
    input  logic            [sched_pkg::NUM_OPS-1:0]  src_ready_i,
    input  sched_pkg::tag_t [sched_pkg::NUM_OPS-1:0]  src_tag_i,
    input  logic                                      cpl_valid_i,
    input  sched_pkg::tag_t                           cpl_tag_i,
    output logic                                      disp_valid_o,
    output sched_pkg::tag_t                           disp_tag_o,
    output sched_pkg::subwarp_t                       disp_subwarp_o,
    output sched_pkg::reg_idx_t                       disp_dst_o
);

    // ##################
    // Slot state
    // ##################

    logic                [sched_pkg::NUM_TAGS-1:0]                         slot_valid_q;
    sched_pkg::subwarp_t [sched_pkg::NUM_TAGS-1:0]                         slot_subwarp_q;
    sched_pkg::reg_idx_t [sched_pkg::NUM_TAGS-1:0]                         slot_dst_q;
    logic                [sched_pkg::NUM_TAGS-1:0][sched_pkg::NUM_OPS-1:0] slot_rdy_q;
    sched_pkg::tag_t     [sched_pkg::NUM_TAGS-1:0][sched_pkg::NUM_OPS-1:0] slot_src_tag_q;

    // Selected slot for this cycle
    logic            sel_valid;
    sched_pkg::tag_t sel_idx;

    // Registered dispatch stage
    logic                disp_valid_q;
    sched_pkg::tag_t     disp_tag_q;
    sched_pkg::subwarp_t disp_subwarp_q;
    sched_pkg::reg_idx_t disp_dst_q;

    // ##################
    // Ready slot select
    // ##################

    // Lowest valid slot with every operand ready
    always_comb begin
        sel_valid = 1'b0;
        sel_idx   = '0;
        for (int s = sched_pkg::NUM_TAGS - 1; s >= 0; s--) begin
            if (slot_valid_q[s] && &slot_rdy_q[s]) begin
                sel_valid = 1'b1;
                sel_idx   = sched_pkg::tag_t'(s);
            end
        end
    end

    // ##################
    // Slot updates
    // ##################

    // Insert sets, dispatch clears; never the same slot
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            slot_valid_q <= '0;
        end else begin
            if (sel_valid) begin
                slot_valid_q[sel_idx] <= 1'b0;
            end
            if (insert_i) begin
                slot_valid_q[tag_i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int s = 0; s < sched_pkg::NUM_TAGS; s++) begin
            for (int op = 0; op < sched_pkg::NUM_OPS; op++) begin
                if (insert_i && tag_i == sched_pkg::tag_t'(s)) begin
                    slot_rdy_q[s][op]     <= src_ready_i[op];
                    slot_src_tag_q[s][op] <= src_tag_i[op];
                end else if (cpl_valid_i && slot_src_tag_q[s][op] == cpl_tag_i) begin
                    // Wakeup from the completion broadcast
                    slot_rdy_q[s][op] <= 1'b1;
                end
            end
        end
        if (insert_i) begin
            slot_subwarp_q[tag_i] <= subwarp_i;
            slot_dst_q[tag_i]     <= dst_i;
        end
    end

    // ##################
    // Dispatch stage
    // ##################

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            disp_valid_q <= 1'b0;
        end else begin
            disp_valid_q <= sel_valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (sel_valid) begin
            disp_tag_q     <= sel_idx;
            disp_subwarp_q <= slot_subwarp_q[sel_idx];
            disp_dst_q     <= slot_dst_q[sel_idx];
        end
    end

    assign disp_valid_o   = disp_valid_q;
    assign disp_tag_o     = disp_tag_q;
    assign disp_subwarp_o = disp_subwarp_q;
    assign disp_dst_o     = disp_dst_q;

endmodule
